/* nes_bus_defines.svh */
`ifndef NES_BUS_DEFINES_SVH
`define NES_BUS_DEFINES_SVH

//////////////////////////////
// Clocking
//////////////////////////////

`define NES_CE_DIVIDE       3         // Master clocks per CPU cycle

//////////////////////////////
// Raster
//////////////////////////////

`define NES_DOTS_PER_LINE   341
`define NES_LINES_PER_FRAME 262
`define NES_VISIBLE_DOTS    256
`define NES_VISIBLE_LINES   240
`define NES_VBLANK_LINE     241       // First line of vertical blank
`define NES_PRERENDER_LINE  261

//////////////////////////////
// CPU address map
//////////////////////////////

`define NES_RAM_MASK        11        // 2 KB work RAM, mirrored up to 0x1FFF
`define NES_PPU_BASE        16'h2000
`define NES_IO_BASE         16'h4000  // APU and controllers, not decoded here
`define NES_PRG_BASE        16'h8000

`endif

/* nes_bus_pkg.sv */
`default_nettype none

package nes_bus_pkg;

    //////////////////////////////
    // CPU side
    //////////////////////////////

    // One CPU bus cycle as seen on the pins
    typedef struct packed {
        logic [15:0] address;
        logic        rw;          // 1 = read
        logic [7:0]  data;        // Write data
    } cpu_bus_t;

    // Decoded target of a CPU address
    typedef enum logic [1:0] {
        REGION_RAM  = 2'd0,
        REGION_PPU  = 2'd1,
        REGION_NONE = 2'd2,       // Open space, reads as zero
        REGION_PRG  = 2'd3
    } cpu_region_t;

    //////////////////////////////
    // PPU side
    //////////////////////////////

    // Access to one of the eight PPU registers
    typedef struct packed {
        logic       valid;        // High for a single enable cycle
        logic [2:0] sel;          // Register select, CPU address bits 2..0
        logic       rw;
        logic [7:0] data;
    } ppu_reg_req_t;

    // PPU video memory access
    typedef struct packed {
        logic [13:0] address;
        logic        rd;
        logic        we;
        logic [7:0]  data;
    } ppu_video_bus_t;

endpackage

`default_nettype wire

/* nes_bus_ctrl.sv */
`default_nettype none

`include "nes_bus_defines.svh"

module nes_bus_ctrl (
    input  wire                      i_clk,
    input  wire                      i_rst,
    input  wire [15:0]               i_address,
    output logic                     o_ce_cpu,
    output nes_bus_pkg::cpu_region_t o_region
);

    localparam int CNT_W = $clog2(`NES_CE_DIVIDE);

    //////////////////////////////
    // CPU clock enable
    //////////////////////////////

    logic [CNT_W-1:0] ce_cnt;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ce_cnt <= '0;
        end else if (ce_cnt == CNT_W'(`NES_CE_DIVIDE - 1)) begin
            ce_cnt <= '0;
        end else begin
            ce_cnt <= ce_cnt + 1'b1;
        end
    end

    // Last count of each period, so the first pulse lands on the third clock
    assign o_ce_cpu = (ce_cnt == CNT_W'(`NES_CE_DIVIDE - 1));

    //////////////////////////////
    // Address decode
    //////////////////////////////

    always_comb begin
        if (i_address < `NES_PPU_BASE) begin
            o_region = nes_bus_pkg::REGION_RAM;
        end else if (i_address < `NES_IO_BASE) begin
            o_region = nes_bus_pkg::REGION_PPU;
        end else if (i_address >= `NES_PRG_BASE) begin
            o_region = nes_bus_pkg::REGION_PRG;  // Cartridge space, 0x8000 up
        end else begin
            o_region = nes_bus_pkg::REGION_NONE;
        end
    end

endmodule

`default_nettype wire

/* cpu_memory_map.sv */
`default_nettype none

`include "nes_bus_defines.svh"

module cpu_memory_map (
    // Control and request
    input  wire                       i_ce_cpu,
    input  nes_bus_pkg::cpu_region_t  i_region,
    input  nes_bus_pkg::cpu_bus_t     i_cpu,
    output logic [7:0]                o_cpu_data,

    // RAM (read / write)
    output logic                      o_cs_ram,
    output logic [15:0]               o_address_ram,
    output logic                      o_rw_ram,
    output logic [7:0]                o_data_ram,
    input  wire  [7:0]                i_data_ram,

    // PRG (read only)
    output logic                      o_cs_prg,
    output logic [15:0]               o_address_prg,
    input  wire  [7:0]                i_data_prg,

    // PPU register port
    output nes_bus_pkg::ppu_reg_req_t o_ppu_req,
    input  wire  [7:0]                i_ppu_data
);

    // Selects only live in the enable cycle
    assign o_cs_ram = i_ce_cpu && (i_region == nes_bus_pkg::REGION_RAM);
    assign o_cs_prg = i_ce_cpu && (i_region == nes_bus_pkg::REGION_PRG);

    assign o_address_ram = 16'(i_cpu.address[`NES_RAM_MASK-1:0]);  // 2 KB mirror
    assign o_rw_ram      = i_cpu.rw;
    assign o_data_ram    = i_cpu.data;

    assign o_address_prg = {1'b0, i_cpu.address[14:0]};

    // PPU registers repeat every 8 bytes through 0x3FFF
    assign o_ppu_req.valid = i_ce_cpu && (i_region == nes_bus_pkg::REGION_PPU);
    assign o_ppu_req.sel   = i_cpu.address[2:0];
    assign o_ppu_req.rw    = i_cpu.rw;
    assign o_ppu_req.data  = i_cpu.data;

    //////////////////////////////
    // Read data return
    //////////////////////////////

    always_comb begin
        case (i_region)
            nes_bus_pkg::REGION_RAM: o_cpu_data = i_data_ram;
            nes_bus_pkg::REGION_PPU: o_cpu_data = i_ppu_data;
            nes_bus_pkg::REGION_PRG: o_cpu_data = i_data_prg;
            default:                 o_cpu_data = 8'h00;    // Nothing mapped
        endcase
    end

endmodule

`default_nettype wire

/* ppu_registers.sv */
`default_nettype none

module ppu_registers (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  nes_bus_pkg::ppu_reg_req_t    i_req,
    output logic [7:0]                   o_data,
    output nes_bus_pkg::ppu_video_bus_t  o_video,
    input  wire  [7:0]                   i_video_data,
    input  wire                          i_vblank_set,
    input  wire                          i_vblank_clear,
    output logic                         o_nmi_n
);

    localparam logic [2:0] REG_CTRL   = 3'd0;
    localparam logic [2:0] REG_MASK   = 3'd1;
    localparam logic [2:0] REG_STATUS = 3'd2;
    localparam logic [2:0] REG_ADDR   = 3'd6;
    localparam logic [2:0] REG_DATA   = 3'd7;

    logic [7:0]  ppuctrl;
    logic [7:0]  ppumask;         // Kept for software, rendering is not modelled
    logic        vblank;
    logic        addr_latch;      // 0 = next PPUADDR write is the high byte
    logic [13:0] vram_addr;
    logic [7:0]  read_buf;

    logic        wr_strobe;
    logic        rd_strobe;
    logic        status_rd;
    logic        palette_addr;
    logic [13:0] addr_step;

    assign wr_strobe    = i_req.valid && !i_req.rw;
    assign rd_strobe    = i_req.valid && i_req.rw;
    assign status_rd    = rd_strobe && (i_req.sel == REG_STATUS);
    assign palette_addr = (vram_addr[13:8] == 6'h3F);
    assign addr_step    = ppuctrl[2] ? 14'd32 : 14'd1;  // Across or down a nametable

    //////////////////////////////
    // Video bus, pre-increment address
    //////////////////////////////

    assign o_video.address = vram_addr;
    assign o_video.rd      = rd_strobe && (i_req.sel == REG_DATA);
    assign o_video.we      = wr_strobe && (i_req.sel == REG_DATA);
    assign o_video.data    = i_req.data;

    always_comb begin
        case (i_req.sel)
            REG_STATUS: o_data = {vblank, 7'b0};
            REG_DATA:   o_data = palette_addr ? i_video_data : read_buf;
            default:    o_data = 8'h00;           // Write-only registers
        endcase
    end

    assign o_nmi_n = !(vblank && ppuctrl[7]);

    //////////////////////////////
    // Register updates
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ppuctrl    <= '0;
            ppumask    <= '0;
            vblank     <= 1'b0;
            addr_latch <= 1'b0;
            vram_addr  <= '0;
            read_buf   <= '0;
        end else begin
            // Status read on the set dot loses the flag, as on the real part
            if (i_vblank_set && !status_rd) begin
                vblank <= 1'b1;
            end else if (i_vblank_clear || status_rd) begin
                vblank <= 1'b0;
            end

            if (wr_strobe) begin
                case (i_req.sel)
                    REG_CTRL: ppuctrl <= i_req.data;
                    REG_MASK: ppumask <= i_req.data;
                    REG_ADDR: begin
                        if (!addr_latch) begin
                            vram_addr[13:8] <= i_req.data[5:0];
                        end else begin
                            vram_addr[7:0] <= i_req.data;
                        end
                        addr_latch <= !addr_latch;
                    end
                    REG_DATA: vram_addr <= vram_addr + addr_step;
                    default: ;
                endcase
            end

            if (rd_strobe) begin
                case (i_req.sel)
                    REG_STATUS: addr_latch <= 1'b0;
                    REG_DATA: begin
                        if (!palette_addr) begin
                            read_buf <= i_video_data;  // Delayed by one read
                        end
                        vram_addr <= vram_addr + addr_step;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* ppu_timing.sv */
`default_nettype none

`include "nes_bus_defines.svh"

module ppu_timing (
    input  wire        i_clk,
    input  wire        i_rst,
    output logic [8:0] o_x,
    output logic [8:0] o_y,
    output logic       o_visible,
    output logic       o_vblank_set,
    output logic       o_vblank_clear
);

    logic [8:0] dot;
    logic [8:0] line;

    // One dot per master clock
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            dot  <= '0;
            line <= '0;
        end else if (dot == 9'(`NES_DOTS_PER_LINE - 1)) begin
            dot <= '0;
            if (line == 9'(`NES_LINES_PER_FRAME - 1)) begin
                line <= '0;                        // Frame wrap
            end else begin
                line <= line + 1'b1;
            end
        end else begin
            dot <= dot + 1'b1;
        end
    end

    assign o_x       = dot;
    assign o_y       = line;
    assign o_visible = (dot < 9'(`NES_VISIBLE_DOTS)) && (line < 9'(`NES_VISIBLE_LINES));

    // Flag edges fall on dot 1 of their line
    assign o_vblank_set   = (line == 9'(`NES_VBLANK_LINE)) && (dot == 9'd1);
    assign o_vblank_clear = (line == 9'(`NES_PRERENDER_LINE)) && (dot == 9'd1);

endmodule

`default_nettype wire

/* ppu_memory_map.sv */
`default_nettype none

module ppu_memory_map (
    // Request and return
    input  wire                         i_clk,
    input  nes_bus_pkg::ppu_video_bus_t i_video,
    output logic [7:0]                  o_video_data,

    // Pattern table
    output logic                        o_cs_patterntable,
    output logic                        o_rw_patterntable,
    output logic [13:0]                 o_address_patterntable,
    input  wire  [7:0]                  i_data_patterntable,

    // Nametable
    output logic                        o_cs_nametable,
    output logic                        o_rw_nametable,
    output logic [13:0]                 o_address_nametable,
    output logic [7:0]                  o_data_nametable,
    input  wire  [7:0]                  i_data_nametable
);

    logic [7:0] palette [32];

    logic pattern_hit;
    logic palette_hit;
    logic nametable_hit;
    logic access;

    assign pattern_hit   = !i_video.address[13];                // 0x0000 - 0x1FFF
    assign palette_hit   = (i_video.address[13:8] == 6'h3F);    // 0x3F00 - 0x3FFF
    assign nametable_hit = i_video.address[13] && !palette_hit;
    assign access        = i_video.rd || i_video.we;

    assign o_cs_patterntable      = pattern_hit && access;
    assign o_rw_patterntable      = !i_video.we;
    assign o_address_patterntable = i_video.address;

    assign o_cs_nametable      = nametable_hit && access;
    assign o_rw_nametable      = !i_video.we;
    assign o_address_nametable = 14'(i_video.address[10:0]);   // Vertical mirroring
    assign o_data_nametable    = i_video.data;

    // Palette lives inside the PPU
    always_ff @(posedge i_clk) begin
        if (palette_hit && i_video.we) begin
            palette[i_video.address[4:0]] <= i_video.data;
        end
    end

    always_comb begin
        if (palette_hit) begin
            o_video_data = palette[i_video.address[4:0]];
        end else if (pattern_hit) begin
            o_video_data = i_data_patterntable;
        end else begin
            o_video_data = i_data_nametable;
        end
    end

endmodule

`default_nettype wire

/* nes_bus.sv */
`default_nettype none

module nes_bus (
    input  wire                    i_clk,
    input  wire                    i_rst,

    //////////////////////////////
    // CPU bus
    //////////////////////////////

    input  nes_bus_pkg::cpu_bus_t  i_cpu,
    output logic [7:0]             o_cpu_data,
    output logic                   o_ce_cpu,

    // RAM (read / write)
    output logic                   o_cs_ram,
    output logic [15:0]            o_address_ram,
    output logic                   o_rw_ram,
    output logic [7:0]             o_data_ram,
    input  wire  [7:0]             i_data_ram,

    // PRG (read only)
    output logic                   o_cs_prg,
    output logic [15:0]            o_address_prg,
    input  wire  [7:0]             i_data_prg,

    //////////////////////////////
    // PPU memory
    //////////////////////////////

    output logic                   o_cs_patterntable,
    output logic                   o_rw_patterntable,
    output logic [13:0]            o_address_patterntable,
    input  wire  [7:0]             i_data_patterntable,

    output logic                   o_cs_nametable,
    output logic                   o_rw_nametable,
    output logic [13:0]            o_address_nametable,
    output logic [7:0]             o_data_nametable,
    input  wire  [7:0]             i_data_nametable,

    //////////////////////////////
    // Video timing
    //////////////////////////////

    output logic [8:0]             o_video_x,
    output logic [8:0]             o_video_y,
    output logic                   o_video_visible,
    output logic                   o_nmi_n
);

    nes_bus_pkg::cpu_region_t    w_region;
    nes_bus_pkg::ppu_reg_req_t   w_ppu_req;
    logic [7:0]                  w_ppu_data;
    nes_bus_pkg::ppu_video_bus_t w_video;
    logic [7:0]                  w_video_data;
    logic                        w_vblank_set;
    logic                        w_vblank_clear;

    nes_bus_ctrl ctrl_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_address(i_cpu.address),
        .o_ce_cpu(o_ce_cpu),
        .o_region(w_region)
    );

    cpu_memory_map cpu_map_i (
        .i_ce_cpu(o_ce_cpu),
        .i_region(w_region),
        .i_cpu(i_cpu),
        .o_cpu_data(o_cpu_data),
        .o_cs_ram(o_cs_ram),
        .o_address_ram(o_address_ram),
        .o_rw_ram(o_rw_ram),
        .o_data_ram(o_data_ram),
        .i_data_ram(i_data_ram),
        .o_cs_prg(o_cs_prg),
        .o_address_prg(o_address_prg),
        .i_data_prg(i_data_prg),
        .o_ppu_req(w_ppu_req),
        .i_ppu_data(w_ppu_data)
    );

    ppu_registers ppu_regs_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_req(w_ppu_req),
        .o_data(w_ppu_data),
        .o_video(w_video),
        .i_video_data(w_video_data),
        .i_vblank_set(w_vblank_set),
        .i_vblank_clear(w_vblank_clear),
        .o_nmi_n(o_nmi_n)
    );

    ppu_timing ppu_timing_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .o_x(o_video_x),
        .o_y(o_video_y),
        .o_visible(o_video_visible),
        .o_vblank_set(w_vblank_set),
        .o_vblank_clear(w_vblank_clear)
    );

    ppu_memory_map ppu_map_i (
        .i_clk(i_clk),
        .i_video(w_video),
        .o_video_data(w_video_data),
        .o_cs_patterntable(o_cs_patterntable),
        .o_rw_patterntable(o_rw_patterntable),
        .o_address_patterntable(o_address_patterntable),
        .i_data_patterntable(i_data_patterntable),
        .o_cs_nametable(o_cs_nametable),
        .o_rw_nametable(o_rw_nametable),
        .o_address_nametable(o_address_nametable),
        .o_data_nametable(o_data_nametable),
        .i_data_nametable(i_data_nametable)
    );

endmodule

`default_nettype wire

/* tb_nes_bus.sv */
`default_nettype none

`include "nes_bus_defines.svh"

module tb_nes_bus;

    localparam int CE_TIMEOUT    = 4 * `NES_CE_DIVIDE;
    localparam int FRAME_TIMEOUT = 2 * `NES_DOTS_PER_LINE * `NES_LINES_PER_FRAME;

    logic                  clk;
    logic                  rst;
    nes_bus_pkg::cpu_bus_t cpu_req;

    logic [7:0]  cpu_data;
    logic        ce_cpu;
    logic        cs_ram, rw_ram, cs_prg;
    logic [15:0] address_ram, address_prg;
    logic [7:0]  data_ram;
    logic        cs_pt, rw_pt, cs_nt, rw_nt;
    logic [13:0] address_pt, address_nt;
    logic [7:0]  data_nt;
    logic [8:0]  video_x, video_y;
    logic        video_visible, nmi_n;

    // Memory models behind the bus
    logic [7:0] ram_mem [2048];
    logic [7:0] prg_mem [32768];
    logic [7:0] pat_mem [8192];
    logic [7:0] nt_mem  [2048];

    // Outputs captured in the middle of the last enable cycle
    logic [7:0]  seen_data, seen_wdata_ram, seen_wdata_nt;
    logic        seen_cs_ram, seen_rw_ram, seen_cs_prg, seen_cs_pt, seen_cs_nt, seen_rw_nt;
    logic        seen_rw_pt;
    logic [15:0] seen_addr_ram, seen_addr_prg;
    logic [13:0] seen_addr_nt;

    logic [7:0] ppu_read_buf;   // What the PPUDATA buffer should hold

    nes_bus dut_i (
        .i_clk(clk),
        .i_rst(rst),
        .i_cpu(cpu_req),
        .o_cpu_data(cpu_data),
        .o_ce_cpu(ce_cpu),
        .o_cs_ram(cs_ram),
        .o_address_ram(address_ram),
        .o_rw_ram(rw_ram),
        .o_data_ram(data_ram),
        .i_data_ram(ram_mem[address_ram[10:0]]),
        .o_cs_prg(cs_prg),
        .o_address_prg(address_prg),
        .i_data_prg(prg_mem[address_prg[14:0]]),
        .o_cs_patterntable(cs_pt),
        .o_rw_patterntable(rw_pt),
        .o_address_patterntable(address_pt),
        .i_data_patterntable(pat_mem[address_pt[12:0]]),
        .o_cs_nametable(cs_nt),
        .o_rw_nametable(rw_nt),
        .o_address_nametable(address_nt),
        .o_data_nametable(data_nt),
        .i_data_nametable(nt_mem[address_nt[10:0]]),
        .o_video_x(video_x),
        .o_video_y(video_y),
        .o_video_visible(video_visible),
        .o_nmi_n(nmi_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Writable models commit on the edge that ends the access
    always @(posedge clk) begin
        if (cs_ram && !rw_ram) ram_mem[address_ram[10:0]] <= data_ram;
        if (cs_nt && !rw_nt) nt_mem[address_nt[10:0]] <= data_nt;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [7:0] fill_byte(input int unsigned a);
        return 8'(a ^ (a >> 5) ^ (a >> 11));   // Every address bit counts
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                                    $time, name, actual, expected));
        end
    endtask

    // One CPU bus cycle, starting and ending 5 units after a rising edge
    task automatic cpu_access(input logic [15:0] addr, input logic rd, input logic [7:0] wdata);
        int cycles;
        cycles = 0;
        cpu_req = '{address: addr, rw: rd, data: wdata};
        while (!ce_cpu) begin
            @(posedge clk);
            #5;
            cycles++;
            if (cycles > CE_TIMEOUT) stop_on_error("Timed out waiting for the CPU clock enable");
        end
        #10;
        seen_data      = cpu_data;
        seen_cs_ram    = cs_ram;
        seen_rw_ram    = rw_ram;
        seen_addr_ram  = address_ram;
        seen_wdata_ram = data_ram;
        seen_cs_prg    = cs_prg;
        seen_addr_prg  = address_prg;
        seen_cs_pt     = cs_pt;
        seen_rw_pt     = rw_pt;
        seen_cs_nt     = cs_nt;
        seen_rw_nt     = rw_nt;
        seen_addr_nt   = address_nt;
        seen_wdata_nt  = data_nt;
        @(posedge clk);
        #5;
        cpu_req = '{address: 16'h5000, rw: 1'b1, data: 8'h00};  // Idle on open space
    endtask

    task automatic set_ppu_address(input logic [13:0] addr);
        cpu_access(16'h2006, 1'b0, {2'b00, addr[13:8]});
        cpu_access(16'h2006, 1'b0, addr[7:0]);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_ram_mirror;
        logic [7:0] d;
        d = 8'($urandom);
        cpu_access(16'h0805, 1'b0, d);
        check_value("o_cs_ram", seen_cs_ram, 1);
        check_value("o_rw_ram", seen_rw_ram, 0);
        check_value("o_address_ram", seen_addr_ram, 16'h0005);
        check_value("o_data_ram", seen_wdata_ram, d);
        cpu_access(16'h1805, 1'b1, 8'h00);          // Same byte, other mirror
        check_value("o_cs_ram", seen_cs_ram, 1);
        check_value("o_cpu_data", seen_data, d);
        cpu_access(16'h5000, 1'b1, 8'h00);
        check_value("o_cs_ram", seen_cs_ram, 0);
        check_value("o_cs_prg", seen_cs_prg, 0);
        check_value("o_cpu_data", seen_data, 8'h00);
    endtask

    task automatic test_prg_read;
        cpu_access(16'hC123, 1'b1, 8'h00);
        check_value("o_cs_prg", seen_cs_prg, 1);
        check_value("o_address_prg", seen_addr_prg, 16'h4123);
        check_value("o_cpu_data", seen_data, fill_byte(32'h4123));
    endtask

    task automatic test_ppudata_write;
        logic [7:0] d [4];
        logic [10:0] expect_addr [4];
        expect_addr = '{11'h400, 11'h401, 11'h402, 11'h422};
        for (int i = 0; i < 4; i++) d[i] = 8'($urandom);
        set_ppu_address(14'h2400);
        for (int i = 0; i < 4; i++) begin
            // Step of 32 from the third write on
            if (i == 2) cpu_access(16'h2000, 1'b0, 8'h04);
            cpu_access(16'h2007, 1'b0, d[i]);
            check_value("o_cs_nametable", seen_cs_nt, 1);
            check_value("o_rw_nametable", seen_rw_nt, 0);
            check_value("o_address_nametable", seen_addr_nt, 14'(expect_addr[i]));
            check_value("o_data_nametable", seen_wdata_nt, d[i]);
            check_value("nametable model", nt_mem[expect_addr[i]], d[i]);
        end
    endtask

    task automatic test_ppudata_read;
        cpu_access(16'h2000, 1'b0, 8'h00);
        set_ppu_address(14'h0100);
        cpu_access(16'h2007, 1'b1, 8'h00);
        check_value("o_cs_patterntable", seen_cs_pt, 1);
        check_value("o_rw_patterntable", seen_rw_pt, 1);
        check_value("o_cpu_data", seen_data, ppu_read_buf);
        ppu_read_buf = pat_mem[13'h100];
        cpu_access(16'h2007, 1'b1, 8'h00);
        check_value("o_cpu_data", seen_data, ppu_read_buf);
        ppu_read_buf = pat_mem[13'h101];
    endtask

    task automatic test_palette;
        logic [7:0] d;
        d = 8'($urandom);
        set_ppu_address(14'h3F05);
        cpu_access(16'h2007, 1'b0, d);
        check_value("o_cs_nametable", seen_cs_nt, 0);
        check_value("o_cs_patterntable", seen_cs_pt, 0);
        set_ppu_address(14'h3F05);
        cpu_access(16'h2007, 1'b1, 8'h00);          // No buffer delay here
        check_value("o_cs_nametable", seen_cs_nt, 0);
        check_value("o_cpu_data", seen_data, d);
    endtask

    task automatic test_vblank_nmi;
        int cycles;
        cycles = 0;
        cpu_access(16'h2000, 1'b0, 8'h80);
        // Flag sets at dot 1 and shows from dot 2
        while (!(video_y == `NES_VBLANK_LINE && video_x >= 2)) begin
            @(posedge clk);
            #5;
            cycles++;
            if (cycles > FRAME_TIMEOUT) stop_on_error("Timed out waiting for the vblank line");
        end
        check_value("o_video_visible", video_visible, 0);
        check_value("o_nmi_n", nmi_n, 0);
        cpu_access(16'h2002, 1'b1, 8'h00);
        check_value("PPUSTATUS", seen_data, 8'h80);
        check_value("o_nmi_n", nmi_n, 1);
        cpu_access(16'h2002, 1'b1, 8'h00);
        check_value("PPUSTATUS", seen_data, 8'h00);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int cycles;
        void'($urandom(32'hc7c7));
        rst          = 1'b1;
        cpu_req      = '{address: 16'h5000, rw: 1'b1, data: 8'h00};
        ppu_read_buf = 8'h00;
        for (int a = 0; a < 2048; a++) ram_mem[a] = fill_byte(a);
        for (int a = 0; a < 32768; a++) prg_mem[a] = fill_byte(a);
        for (int a = 0; a < 8192; a++) pat_mem[a] = fill_byte(a);
        for (int a = 0; a < 2048; a++) nt_mem[a] = fill_byte(a);

        repeat (3) @(posedge clk);
        #5;
        check_value("o_ce_cpu", ce_cpu, 0);
        check_value("o_cs_ram", cs_ram, 0);
        check_value("o_cs_prg", cs_prg, 0);
        check_value("o_cs_patterntable", cs_pt, 0);
        check_value("o_cs_nametable", cs_nt, 0);
        check_value("o_nmi_n", nmi_n, 1);
        // Raster held at the first dot of the first line
        check_value("o_video_x", video_x, 0);
        check_value("o_video_y", video_y, 0);
        check_value("o_video_visible", video_visible, 1);
        rst = 1'b0;

        // First enable lands in the third clock period after release
        cycles = 0;
        while (!ce_cpu) begin
            @(posedge clk);
            #5;
            cycles++;
            if (cycles > CE_TIMEOUT) stop_on_error("Clock enable never came after reset");
        end
        check_value("edges to first o_ce_cpu", cycles, 2);
        check_value("o_video_x", video_x, 2);       // One dot per clock

        test_ram_mirror();
        test_prg_read();
        test_ppudata_write();
        test_ppudata_read();
        test_palette();
        test_vblank_nmi();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* nes_bus.f */
+incdir+.
nes_bus_pkg.sv
nes_bus_ctrl.sv
cpu_memory_map.sv
ppu_registers.sv
ppu_timing.sv
ppu_memory_map.sv
nes_bus.sv
tb_nes_bus.sv

/* Bender.yml */
package:
  name: nes_bus

export_include_dirs:
  - .

sources:
  - nes_bus_pkg.sv
  - nes_bus_ctrl.sv
  - cpu_memory_map.sv
  - ppu_registers.sv
  - ppu_timing.sv
  - ppu_memory_map.sv
  - nes_bus.sv
  - target: simulation
    files:
      - tb_nes_bus.sv
